// File: common/nn_fixed_pkg.sv
// Fixed-point format package: word layout, saturation limits and the widths of wide results
package nn_fixed_pkg;

	// Word layout, sign + integer + fraction
	localparam int FIX_WIDTH = 16;                        // Total bits of a value
	localparam int INT_BITS  = 5;                         // Integer bits, sign not counted
	localparam int FRAC_BITS = FIX_WIDTH - INT_BITS - 1;  // 10 fraction bits

	// Intermediate widths in the cost datapath
	localparam int DIFF_WIDTH = FIX_WIDTH + 1;  // act - ans cannot overflow here
	localparam int PROD_WIDTH = 2 * FIX_WIDTH;  // Full product of two words

	// Signed fixed-point word
	typedef logic signed [FIX_WIDTH-1:0] fix_t;

	// One extra bit of headroom for the difference
	typedef logic signed [DIFF_WIDTH-1:0] diff_t;

	// Full-width product before rescaling
	typedef logic signed [PROD_WIDTH-1:0] prod_t;

	// 1.0 in fixed point, 0x0400 with 10 fraction bits
	localparam fix_t FIX_ONE = fix_t'(2 ** FRAC_BITS);

	// Saturation bounds
	localparam fix_t FIX_MAX = {1'b0, {(FIX_WIDTH-1){1'b1}}};  // Just under 32.0
	localparam fix_t FIX_MIN = {1'b1, {(FIX_WIDTH-1){1'b0}}};  // Exactly -32.0

	/*
	 * Numbers follow the usual two's complement Q5.10 layout:
	 *   bit 15      sign
	 *   bits 14..10 integer part
	 *   bits 9..0   fraction
	 * A product of two words carries 20 fraction bits, so it is shifted
	 * right by FRAC_BITS to get back to the word scale, then clipped.
	 * Arithmetic shift rounds toward minus infinity, as the multiplier in
	 * the rest of the network does.
	 * Sigmoid derivatives lie in 0..0.25 so the quadratic product rarely
	 * saturates in normal training. The clip matters for unusual inputs
	 */

endpackage

// File: common/out_layer_pkg.sv
// Output-layer package: geometry, cycle timing, lane types and delta-memory port structs
package out_layer_pkg;
	import nn_fixed_pkg::*;

	// Network geometry
	localparam int NEURONS      = 4;  // Output neurons
	localparam int LANES        = 1;  // Neurons handled per clock
	localparam int LAYERS       = 3;  // Layers in the whole network
	localparam int EXTRA_CLOCKS = 2;  // Pipeline slack in every block

	// Clocks per block, one block per cycle_clk pulse
	localparam int CPC = NEURONS / LANES + EXTRA_CLOCKS;

	// Words in each delta bank
	localparam int DEPTH = NEURONS / LANES;

	// Labels travel with the activations through LAYERS-1 junctions
	localparam int ANS_DELAY = CPC * (LAYERS - 1);

	// 0 quadratic, 1 cross-entropy
	localparam int COST_FN = 0;

	// Counter and address widths
	localparam int CYC_W  = (CPC > 1) ? $clog2(CPC) : 1;
	localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	typedef logic [CYC_W-1:0]  cycle_idx_t;  // 0 .. CPC-1
	typedef logic [ADDR_W-1:0] dmem_addr_t;  // 0 .. DEPTH-1

	// One fixed-point word per lane
	typedef fix_t [LANES-1:0] fix_lanes_t;

	// Ideal-answer bits, one per lane
	typedef logic [LANES-1:0] ans_lanes_t;

	// Forward data from the last hidden layer
	typedef struct packed {
		fix_lanes_t act;   // Activation
		fix_lanes_t adot;  // Activation derivative
	} fwd_sample_t;

	// Delta memory write port
	typedef struct packed {
		logic       we;    // Write strobe
		logic       bank;  // Target bank
		dmem_addr_t addr;
		fix_lanes_t data;
	} dmem_wr_t;

	// Delta memory read port, data comes back one clock later
	typedef struct packed {
		logic       bank;
		dmem_addr_t addr;
	} dmem_rd_t;

endpackage

// File: logic/ans_delay_line.sv
// Ideal-answer delay line: shifts the label bits by the forward pipeline depth of the network
`timescale 1ns/1ps

module ans_delay_line import out_layer_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  ans_lanes_t ans_i,
	output ans_lanes_t ans_o
);

	// Stage 0 takes the new label, the last stage feeds the cost unit
	ans_lanes_t stage_q [ANS_DELAY];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < ANS_DELAY; i++) begin
				stage_q[i] <= '0;  // No stale labels after reset
			end
		end else begin
			stage_q[0] <= ans_i;
			for (int i = 1; i < ANS_DELAY; i++) begin
				stage_q[i] <= stage_q[i-1];  // Advance one stage per clock
			end
		end
	end

	// Label from ANS_DELAY clocks ago
	assign ans_o = stage_q[ANS_DELAY-1];

endmodule

// File: logic/cost_unit.sv
// Cost unit: turns activation, derivative and label into a per-lane delta, no clock delay
`timescale 1ns/1ps

module cost_unit import nn_fixed_pkg::*, out_layer_pkg::*; #(
	parameter int COST_FN = 0  // 0 quadratic, 1 cross-entropy
) (
	input  fwd_sample_t fwd_i,
	input  ans_lanes_t  ans_i,  // Delayed label
	output fix_lanes_t  del_o
);

	for (genvar l = 0; l < LANES; l++) begin : g_lane
		fix_t  act_l;      // Signed view of this lane
		fix_t  adot_l;
		fix_t  ans_fix;    // Label as 0.0 or 1.0
		diff_t diff_full;  // Exact act - ans
		fix_t  diff_sat;

		assign act_l   = fwd_i.act[l];
		assign adot_l  = fwd_i.adot[l];
		assign ans_fix = ans_i[l] ? FIX_ONE : fix_t'(0);

		// One guard bit, so this never wraps
		assign diff_full = diff_t'(act_l) - diff_t'(ans_fix);

		// Top two bits disagree on overflow, the guard bit gives the direction
		assign diff_sat = (diff_full[DIFF_WIDTH-1] == diff_full[DIFF_WIDTH-2]) ?
			fix_t'(diff_full) :
			(diff_full[DIFF_WIDTH-1] ? FIX_MIN : FIX_MAX);

		if (COST_FN == 0) begin : g_quad
			prod_t prod_full;  // 20 fraction bits
			prod_t prod_shft;  // Back on the word scale

			// Quadratic cost needs (a - y) * sigma'(z)
			assign prod_full = prod_t'(diff_sat) * prod_t'(adot_l);

			// Arithmetic shift, rounds toward minus infinity
			assign prod_shft = prod_full >>> FRAC_BITS;

			// Clip into the word range
			assign del_o[l] = (prod_shft > prod_t'(FIX_MAX)) ? FIX_MAX :
				(prod_shft < prod_t'(FIX_MIN)) ? FIX_MIN : fix_t'(prod_shft);
		end else begin : g_xent
			// Cross-entropy with sigmoid output, the derivative cancels out
			assign del_o[l] = diff_sat;
		end
	end

	/*
	 * The two branches share the difference stage.
	 * In cross-entropy mode adot is simply ignored, the port stays
	 * so the top level does not change with the cost function
	 */

endmodule

// File: delta_mem/delta_bank_ctrl.sv
// Delta bank controller: ping-pong pointer, write strobe and port addresses for the delta memory
`timescale 1ns/1ps

module delta_bank_ctrl import out_layer_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  cycle_idx_t cycle_index_i,
	input  logic       cycle_clk_i,  // Block start strobe
	input  fix_lanes_t del_i,        // Delta from the cost unit
	output dmem_wr_t   wr_o,
	output dmem_rd_t   rd_o
);

	logic       bank_q;     // Ping-pong pointer
	logic       wr_bank;    // Bank being filled this block
	logic       in_window;  // Index inside 0 .. DEPTH-1
	dmem_addr_t idx_addr;

	// Flips at the edge that closes the cycle_clk clock
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			bank_q <= 1'b0;
		end else if (cycle_clk_i) begin
			bank_q <= ~bank_q;
		end
	end

	// During index 0 the register still holds the old block's bank,
	// so look ahead to keep one bank for the whole block
	assign wr_bank = bank_q ^ cycle_clk_i;

	// Only the first DEPTH clocks of a block carry deltas
	assign in_window = (cycle_index_i < cycle_idx_t'(DEPTH));

	// Park the address on the last word in the slack clocks
	assign idx_addr = in_window ? dmem_addr_t'(cycle_index_i) : dmem_addr_t'(DEPTH - 1);

	// Write side fills this block's bank
	assign wr_o.we   = in_window && rst_n_i;  // Nothing stored while in reset
	assign wr_o.bank = wr_bank;
	assign wr_o.addr = idx_addr;
	assign wr_o.data = del_i;

	// Read side replays the previous block from the other bank
	assign rd_o.bank = ~wr_bank;
	assign rd_o.addr = idx_addr;  // Same index, data lands one clock later

endmodule

// File: delta_mem/delta_mem_bank.sv
// Delta memory: two banks of DEPTH words, synchronous write and one-clock registered read
`timescale 1ns/1ps

module delta_mem_bank import out_layer_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  dmem_wr_t   wr_i,   // Write port from the controller
	input  dmem_rd_t   rd_i,   // Read port, other bank
	output fix_lanes_t del_o   // Registered read data
);

	// Bank index first, then word
	fix_lanes_t mem_q [2][DEPTH];
	fix_lanes_t rd_q;

	// Reset wipes both banks so the first replay after reset reads zeros
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int b = 0; b < 2; b++) begin
				for (int w = 0; w < DEPTH; w++) begin
					mem_q[b][w] <= '0;
				end
			end
			rd_q <= '0;
		end else begin
			if (wr_i.we) begin
				mem_q[wr_i.bank][wr_i.addr] <= wr_i.data;  // Fill side
			end
			rd_q <= mem_q[rd_i.bank][rd_i.addr];  // Replay side, every clock
		end
	end

	/*
	 * The controller keeps the ports on opposite banks,
	 * so there is no read-during-write case to resolve
	 */

	assign del_o = rd_q;

endmodule

// File: out_layer/out_layer_top.sv
// Output layer top: delays the labels, forms the deltas and replays them to the earlier layer
`timescale 1ns/1ps

module out_layer_top import out_layer_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  cycle_idx_t  cycle_index_i,  // Network-wide clock-in-block count
	input  logic        cycle_clk_i,    // High while cycle_index_i is 0
	input  fwd_sample_t fwd_i,          // act and adot from the last hidden layer
	input  ans_lanes_t  ans_i,          // Labels as presented at the input layer
	output fix_lanes_t  del_o,          // Deltas back to the last hidden layer
	output ans_lanes_t  ans_o           // Labels aligned to this layer
);

	ans_lanes_t ans_dly;   // Label matching the current activation
	fix_lanes_t del_calc;  // Fresh delta, no register
	dmem_wr_t   dmem_wr;
	dmem_rd_t   dmem_rd;

	// Labels enter at the input layer and must wait out the forward pipeline
	ans_delay_line i_ans_delay_line (
		.clk,
		.rst_n_i,
		.ans_i,
		.ans_o (ans_dly)
	);

	assign ans_o = ans_dly;

	// Cost term, and the derivative product for quadratic cost
	cost_unit #(
		.COST_FN (COST_FN)
	) i_cost_unit (
		.fwd_i,
		.ans_i (ans_dly),
		.del_o (del_calc)
	);

	// Bank pointer and port generation
	delta_bank_ctrl i_delta_bank_ctrl (
		.clk,
		.rst_n_i,
		.cycle_index_i,
		.cycle_clk_i,
		.del_i (del_calc),
		.wr_o  (dmem_wr),
		.rd_o  (dmem_rd)
	);

	// Ping-pong storage, read side drives the output
	delta_mem_bank i_delta_mem_bank (
		.clk,
		.rst_n_i,
		.wr_i  (dmem_wr),
		.rd_i  (dmem_rd),
		.del_o
	);

endmodule

// File: verification/out_layer_assert.sv
// Delta bank controller checks: write window, port bank separation and pointer toggling
`timescale 1ns/1ps

module out_layer_assert import out_layer_pkg::*; (
	input logic       clk,
	input logic       rst_n_i,
	input cycle_idx_t cycle_index_i,
	input logic       cycle_clk_i,
	input dmem_wr_t   wr_i,    // Controller write port
	input dmem_rd_t   rd_i,    // Controller read port
	input logic       bank_i   // Internal ping-pong pointer
);

	// Slack clocks of a block must not store anything
	a_we_window: assert property (@(posedge clk) disable iff (!rst_n_i)
		(cycle_index_i >= cycle_idx_t'(DEPTH)) |-> !wr_i.we)
		else $error("Delta write strobe high at cycle index %0d", cycle_index_i);

	// Write strobe stays low through reset
	a_we_reset: assert property (@(posedge clk)
		!rst_n_i |-> !wr_i.we)
		else $error("Delta write strobe high during reset");

	// Fill and replay never share a bank
	a_bank_split: assert property (@(posedge clk) disable iff (!rst_n_i)
		rd_i.bank != wr_i.bank)
		else $error("Read and write ports both on bank %0d", wr_i.bank);

	// One flip per block start
	a_ptr_flip: assert property (@(posedge clk) disable iff (!rst_n_i)
		cycle_clk_i |=> (bank_i != $past(bank_i)))
		else $error("Bank pointer did not flip after a block start");

	// And none in between
	a_ptr_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		!cycle_clk_i |=> (bank_i == $past(bank_i)))
		else $error("Bank pointer moved without a block start");

endmodule

bind delta_bank_ctrl out_layer_assert i_out_layer_assert (
	.clk           (clk),
	.rst_n_i       (rst_n_i),
	.cycle_index_i (cycle_index_i),
	.cycle_clk_i   (cycle_clk_i),
	.wr_i          (wr_o),
	.rd_i          (rd_o),
	.bank_i        (bank_q)
);

// File: verification/out_layer_tb.sv
// Output layer testbench: random blocks, reference deltas, label delay model and a watchdog
`timescale 1ns/1ps

module out_layer_tb import nn_fixed_pkg::*, out_layer_pkg::*; ();

	localparam int CLK_PERIOD  = 100;  // ns
	localparam int RST_CYCLES  = 10;
	localparam int MAIN_BLOCKS = 40;   // Before the mid-run reset
	localparam int TAIL_BLOCKS = 8;    // After it
	localparam int CUT_CLOCKS  = 3;    // Block cut short by the second reset

	// Each reset and the cut block count as whole blocks
	localparam int BLOCK_COUNT = MAIN_BLOCKS + TAIL_BLOCKS + 1 +
		2 * ((RST_CYCLES + CPC - 1) / CPC);
	localparam int WATCHDOG_NS = (BLOCK_COUNT + 4) * CPC * CLK_PERIOD;

	logic        clk;
	logic        rst_n_i;
	cycle_idx_t  cycle_index_i;
	logic        cycle_clk_i;
	fwd_sample_t fwd_i;
	ans_lanes_t  ans_i;
	fix_lanes_t  del_o;
	ans_lanes_t  ans_o;

	logic [31:0] rnd_state = 32'hbfd6;  // xorshift state
	int          idx;                   // Next cycle index to drive
	int          val_errors;
	int          other_errors;
	int          ans_checks;
	int          del_checks;
	int          sat_seen;              // Reference deltas that hit a bound

	ans_lanes_t ans_q[$];              // Labels in flight, ANS_DELAY deep
	fix_lanes_t mdl_bank [2][DEPTH];   // Ping-pong banks of the model
	bit         wr_sel;                // Model bank being filled
	bit         first_clk;             // First clock after reset

	out_layer_top i_dut (
		.clk,
		.rst_n_i,
		.cycle_index_i,
		.cycle_clk_i,
		.fwd_i,
		.ans_i,
		.del_o,
		.ans_o
	);

	// 32-bit xorshift step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rnd_state = xorshift32(rnd_state);
		return rnd_state;
	endfunction

	// Activation, a quarter of the draws sit near each bound
	function automatic fix_t random_act();
		logic [31:0] r;
		fix_t        v;
		r = next_rand();
		case (r[1:0])
			2'd2:    v = FIX_MAX - fix_t'(r[9:2]);
			2'd3:    v = FIX_MIN + fix_t'(r[9:2]);
			default: v = fix_t'(r[31:16]);
		endcase
		return v;
	endfunction

	// Derivative, sigmoid range mixed with large values that overflow the product
	function automatic fix_t random_adot();
		logic [31:0] r;
		fix_t        v;
		r = next_rand();
		case (r[1:0])
			2'd0:    v = fix_t'(r[24:16]);  // 0 .. about 0.5
			2'd2:    v = FIX_MAX - fix_t'(r[9:2]);
			2'd3:    v = FIX_MIN + fix_t'(r[9:2]);
			default: v = fix_t'(r[31:16]);
		endcase
		return v;
	endfunction

	// Expected delta of one lane
	function automatic fix_t ref_delta(input fix_t act, input fix_t adot, input logic ans);
		longint lo;
		longint hi;
		longint scale;
		longint diff;
		longint prod;
		longint q;
		lo    = longint'(FIX_MIN);
		hi    = longint'(FIX_MAX);
		scale = longint'(1) << FRAC_BITS;
		diff  = longint'(act) - (ans ? longint'(FIX_ONE) : longint'(0));
		diff  = (diff > hi) ? hi : ((diff < lo) ? lo : diff);
		if (COST_FN != 0) begin
			q = diff;  // Cross-entropy, plain difference
		end else begin
			prod = diff * longint'(adot);
			q    = prod / scale;  // Truncates toward zero
			if ((prod % scale != 0) && (prod < 0)) begin
				q = q - 1;  // Floor for negative products
			end
			q = (q > hi) ? hi : ((q < lo) ? lo : q);
		end
		return fix_t'(q);
	endfunction

	// One clock of stimulus, driven on the falling edge
	task automatic drive_clock();
		fwd_sample_t s;
		ans_lanes_t  a;
		logic [31:0] r;
		@(negedge clk);
		for (int l = 0; l < LANES; l++) begin
			r    = next_rand();
			a[l] = r[31];
			if (idx < DEPTH) begin
				s.act[l]  = random_act();
				s.adot[l] = random_adot();
			end else begin
				// Slack clock, would saturate the delta if it were stored
				s.act[l]  = r[0] ? FIX_MAX : FIX_MIN;
				s.adot[l] = r[1] ? FIX_MAX : FIX_MIN;
			end
		end
		rst_n_i       = 1'b1;
		cycle_index_i = cycle_idx_t'(idx);
		cycle_clk_i   = (idx == 0);
		fwd_i         = s;
		ans_i         = a;
		idx           = (idx + 1) % CPC;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n_i       = 1'b0;
		cycle_index_i = '0;
		cycle_clk_i   = 1'b0;
		fwd_i         = '0;
		ans_i         = '0;
		idx           = 0;  // Cycle counter restarts with the network
		repeat (RST_CYCLES - 1) @(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

	// Reference model and comparison, outputs sampled before the edge updates them
	always @(posedge clk) begin : compare
		ans_lanes_t exp_ans;
		fix_lanes_t exp_del;
		fix_lanes_t new_del;
		int         k;
		if (!rst_n_i) begin
			ans_q.delete();
			for (int i = 0; i < ANS_DELAY; i++) begin
				ans_q.push_back('0);
			end
			for (int b = 0; b < 2; b++) begin
				for (int w = 0; w < DEPTH; w++) begin
					mdl_bank[b][w] = '0;
				end
			end
			wr_sel    = 1'b0;
			first_clk = 1'b1;
		end else begin
			k       = int'(cycle_index_i);
			exp_ans = ans_q.pop_front();  // Went in ANS_DELAY clocks ago
			ans_checks++;
			assert (ans_o === exp_ans) else begin
				val_errors++;
				$display("[FAIL] t=%0t ans_o expected %b got %b", $time, exp_ans, ans_o);
			end
			ans_q.push_back(ans_i);
			if (first_clk) begin
				del_checks++;
				assert (del_o === '0) else begin
					val_errors++;
					$display("[FAIL] t=%0t del_o expected %h got %h", $time, fix_lanes_t'(0), del_o);
				end
			end
			if (cycle_clk_i) begin
				wr_sel = ~wr_sel;  // New block, banks swap roles
			end
			// Replay of the previous block, one clock behind its index
			if (k >= 1 && k <= DEPTH) begin
				exp_del = mdl_bank[~wr_sel][k-1];
				del_checks++;
				assert (del_o === exp_del) else begin
					val_errors++;
					$display("[FAIL] t=%0t del_o expected %h got %h", $time, exp_del, del_o);
				end
			end
			if (k < DEPTH) begin
				for (int l = 0; l < LANES; l++) begin
					new_del[l] = ref_delta(fwd_i.act[l], fwd_i.adot[l], exp_ans[l]);
					if (new_del[l] == FIX_MAX || new_del[l] == FIX_MIN) begin
						sat_seen++;
					end
				end
				mdl_bank[wr_sel][k] = new_del;
			end
			first_clk = 1'b0;
		end
	end

	initial begin : stimulus
		rst_n_i       = 1'b0;
		cycle_index_i = '0;
		cycle_clk_i   = 1'b0;
		fwd_i         = '0;
		ans_i         = '0;
		apply_reset();
		repeat (MAIN_BLOCKS * CPC) drive_clock();
		repeat (CUT_CLOCKS) drive_clock();  // Reset lands inside a block
		apply_reset();
		repeat (TAIL_BLOCKS * CPC) drive_clock();
		@(negedge clk);
		assert (sat_seen > 0) else begin
			other_errors++;
			$display("No stored delta reached a saturation bound, overflow went unexercised");
		end
		$display("Checks: %0d ans_o, %0d del_o; errors: %0d value, %0d other",
			ans_checks, del_checks, val_errors, other_errors);
		if (val_errors + other_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
common/nn_fixed_pkg.sv
common/out_layer_pkg.sv
logic/ans_delay_line.sv
logic/cost_unit.sv
delta_mem/delta_bank_ctrl.sv
delta_mem/delta_mem_bank.sv
out_layer/out_layer_top.sv
verification/out_layer_assert.sv
verification/out_layer_tb.sv

// File: Makefile
# Verilator flow for the output layer testbench

VERILATOR  ?= verilator
TOP        ?= out_layer_tb
FLIST      ?= vlog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
